// File: bench/msdap_tb.sv
`timescale 1ns/1ps
`default_nettype none

module msdap_tb;

  import msdap_pkg::*;

  localparam int CLK_HALF    = 20;
  localparam int DRIVE_DLY   = 2;
  localparam int NGRP        = DEF_NUM_GROUPS;
  localparam int NCOEF       = DEF_COEF_DEPTH;
  localparam int MAX_SAMPLES = 512;
  localparam int LOW_LIMIT   = 8;
  localparam int DONE_LIMIT  = 3000;

  logic             Sclk = 1'b0;
  logic             Start;
  logic             frame;
  logic             input_l;
  logic             input_r;
  logic             in_ready;
  logic             out_ready;
  logic [ACC_W-1:0] output_l;
  logic [ACC_W-1:0] output_r;

  // reference copies, index 0 is the left channel
  logic [15:0] rj_tab   [2][NGRP];
  logic [15:0] coef_tab [2][NCOEF];
  logic [15:0] smp_tab  [2][MAX_SAMPLES];
  int          smp_count;

  logic [31:0] lcg_state;
  int          error_count;
  int          check_count;
  int          pulse_count = 0;

  msdap msdap_i (
    .Sclk(Sclk), .Start(Start), .frame(frame),
    .input_l(input_l), .input_r(input_r),
    .in_ready(in_ready), .out_ready(out_ready),
    .output_l(output_l), .output_r(output_r)
  );

  always #CLK_HALF Sclk = ~Sclk;

  // count output strobes away from the active edge
  always @(negedge Sclk)
  begin
    if (out_ready)
    begin
      pulse_count++;
    end
  end

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  function automatic logic [15:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[30:15];
  endfunction

  function automatic logic [15:0] make_coef(input logic neg, input logic [7:0] delay);
    return {7'd0, neg, delay};
  endfunction

  // filter rule applied to the stored copies
  function automatic longint model_output(input int ch, input int n);
    longint      y;
    longint      u;
    longint      term;
    int          ptr;
    int          m;
    logic [15:0] c;
    y   = '0;
    ptr = 0;
    for (int k = 0; k < NGRP; k++)
    begin
      u = '0;
      for (int j = 0; j < int'(rj_tab[ch][k]); j++)
      begin
        c = coef_tab[ch][ptr];
        ptr++;
        m = n - int'(c[7:0]);
        if (m >= 0)
        begin
          term = longint'($signed(smp_tab[ch][m])) <<< FRAC_SHIFT;
          u    = c[8] ? u - term : u + term;
        end
      end
      y = (y + u) >>> 1;
    end
    return y;
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    check_count++;
    if (expected !== actual)
    begin
      error_count++;
      $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    $display("%s finished with %0d errors", name, error_count - errs_before);
  endtask

  task automatic apply_reset();
    Start   = 1'b0;
    frame   = 1'b0;
    input_l = 1'b0;
    input_r = 1'b0;
    repeat (3) @(posedge Sclk);
    #DRIVE_DLY;
    Start     = 1'b1;
    smp_count = 0;
  endtask

  // msb first, frame with the first bit
  task automatic send_word(input logic [15:0] left, input logic [15:0] right);
    for (int b = WORD_W - 1; b >= 0; b--)
    begin
      frame   = (b == WORD_W - 1);
      input_l = left[b];
      input_r = right[b];
      @(posedge Sclk);
      #DRIVE_DLY;
    end
    frame   = 1'b0;
    input_l = 1'b0;
    input_r = 1'b0;
  endtask

  task automatic load_config();
    for (int k = 0; k < NGRP; k++)
    begin
      send_word(rj_tab[0][k], rj_tab[1][k]);
    end
    for (int i = 0; i < NCOEF; i++)
    begin
      send_word(coef_tab[0][i], coef_tab[1][i]);
    end
  endtask

  task automatic wait_in_ready_high(input string name, output bit ok);
    int cycles;
    cycles = 0;
    while (!in_ready && (cycles < DONE_LIMIT))
    begin
      @(posedge Sclk);
      #DRIVE_DLY;
      cycles++;
    end
    ok = in_ready;
    if (!ok)
    begin
      error_count++;
      $display("timeout in %s: in_ready never went high", name);
    end
  endtask

  task automatic wait_in_ready_low(input string name, output bit ok);
    int cycles;
    cycles = 0;
    while (in_ready && (cycles < LOW_LIMIT))
    begin
      @(posedge Sclk);
      #DRIVE_DLY;
      cycles++;
    end
    ok = !in_ready;
    if (!ok)
    begin
      error_count++;
      $display("timeout in %s: in_ready did not drop after a sample", name);
    end
  endtask

  // in_ready must stay low for the whole computation
  task automatic wait_out_ready(input string name, output bit ok);
    int cycles;
    cycles = 0;
    while (!out_ready && (cycles < DONE_LIMIT))
    begin
      if (in_ready)
      begin
        error_count++;
        $display("error in %s: in_ready rose before out_ready", name);
      end
      @(posedge Sclk);
      #DRIVE_DLY;
      cycles++;
    end
    ok = out_ready;
    if (!ok)
    begin
      error_count++;
      $display("timeout in %s: out_ready never arrived", name);
    end
  endtask

  // one accepted sample, optionally followed by a word that must be dropped
  task automatic run_sample(input string name, input logic [15:0] left,
                            input logic [15:0] right, input bit extra_word);
    bit               ok;
    logic [ACC_W-1:0] exp_l;
    logic [ACC_W-1:0] exp_r;
    wait_in_ready_high(name, ok);
    if (ok)
    begin
      smp_tab[0][smp_count] = left;
      smp_tab[1][smp_count] = right;
      send_word(left, right);
      wait_in_ready_low(name, ok);
    end
    if (ok && extra_word)
    begin
      send_word(next_rand(), next_rand());
    end
    if (ok)
    begin
      wait_out_ready(name, ok);
    end
    if (ok)
    begin
      exp_l = ACC_W'(model_output(0, smp_count));
      exp_r = ACC_W'(model_output(1, smp_count));
      check_value($sformatf("%s left sample %0d", name, smp_count),
                  {24'd0, exp_l}, {24'd0, output_l});
      check_value($sformatf("%s right sample %0d", name, smp_count),
                  {24'd0, exp_r}, {24'd0, output_r});
      @(posedge Sclk);
      #DRIVE_DLY;
      check_value($sformatf("%s in_ready after sample %0d", name, smp_count),
                  64'd1, 64'(in_ready));
    end
    smp_count++;
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////

  task automatic test_reset();
    int errs;
    errs = error_count;
    apply_reset();
    check_value("test_reset in_ready", 64'd1, 64'(in_ready));
    check_value("test_reset out_ready", 64'd0, 64'(out_ready));
    check_value("test_reset output_l", 64'd0, 64'(output_l));
    check_value("test_reset output_r", 64'd0, 64'(output_r));
    report_test("test_reset", errs);
  endtask

  task automatic test_impulse();
    int errs;
    int pulses;
    errs = error_count;
    apply_reset();
    for (int k = 0; k < NGRP; k++)
    begin
      rj_tab[0][k] = 16'd1;
      rj_tab[1][k] = 16'd1;
    end
    // words past the last group are never read
    for (int i = 0; i < NCOEF; i++)
    begin
      coef_tab[0][i] = (i < NGRP) ? make_coef(1'b0, 8'd0) : next_rand();
      coef_tab[1][i] = (i < NGRP) ? make_coef(1'b0, 8'd0) : next_rand();
    end
    load_config();
    pulses = pulse_count;
    run_sample("test_impulse", 16'h1234, 16'hc001, 1'b0);
    repeat (100) @(posedge Sclk);
    #DRIVE_DLY;
    check_value("test_impulse out_ready pulses", 64'd1, 64'(pulse_count - pulses));
    report_test("test_impulse", errs);
  endtask

  task automatic test_signed_groups();
    int          errs;
    logic [15:0] r;
    errs = error_count;
    apply_reset();
    // right channel has an empty group at k = 7
    for (int k = 0; k < NGRP; k++)
    begin
      rj_tab[0][k] = 16'(k + 1);
      rj_tab[1][k] = 16'((k * 7 + 3) % 13);
    end
    for (int i = 0; i < NCOEF; i++)
    begin
      r = next_rand();
      coef_tab[0][i] = make_coef(r[8], {2'b00, r[5:0]});
      r = next_rand();
      coef_tab[1][i] = make_coef(r[9], {2'b00, r[6:1]});
    end
    load_config();
    for (int n = 0; n < 40; n++)
    begin
      run_sample("test_signed_groups", next_rand(), next_rand(), 1'b0);
    end
    report_test("test_signed_groups", errs);
  endtask

  task automatic test_history_wrap();
    int         errs;
    logic [7:0] d_l;
    logic [7:0] d_r;
    errs = error_count;
    apply_reset();
    for (int k = 0; k < NGRP; k++)
    begin
      rj_tab[0][k] = 16'd4;
      rj_tab[1][k] = 16'd4;
    end
    for (int i = 0; i < NCOEF; i++)
    begin
      d_l = 8'((i * 83 + 17) % 256);
      d_r = 8'((i * 47 + 5) % 256);
      // deepest taps in every group
      if ((i % 4) == 0)
      begin
        d_l = 8'd255;
      end
      if ((i % 4) == 1)
      begin
        d_r = 8'd255;
      end
      coef_tab[0][i] = make_coef((i % 3) == 0, d_l);
      coef_tab[1][i] = make_coef((i % 5) == 2, d_r);
    end
    load_config();
    for (int n = 0; n < 300; n++)
    begin
      run_sample("test_history_wrap", next_rand(), next_rand(), 1'b0);
    end
    report_test("test_history_wrap", errs);
  endtask

  task automatic test_ready_protocol();
    int          errs;
    int          pulses;
    logic [15:0] r;
    errs = error_count;
    apply_reset();
    for (int k = 0; k < NGRP; k++)
    begin
      rj_tab[0][k] = 16'd8;
      rj_tab[1][k] = 16'd8;
    end
    for (int i = 0; i < NCOEF; i++)
    begin
      r = next_rand();
      coef_tab[0][i] = make_coef(r[12], {4'd0, r[3:0]});
      coef_tab[1][i] = make_coef(r[13], {4'd0, r[7:4]});
    end
    load_config();
    pulses = pulse_count;
    for (int n = 0; n < 8; n++)
    begin
      run_sample("test_ready_protocol", next_rand(), next_rand(), (n % 2) == 1);
    end
    repeat (100) @(posedge Sclk);
    #DRIVE_DLY;
    check_value("test_ready_protocol out_ready pulses", 64'd8,
                64'(pulse_count - pulses));
    report_test("test_ready_protocol", errs);
  endtask

  initial
  begin
    lcg_state   = 32'd76;
    error_count = 0;
    check_count = 0;
    smp_count   = 0;
    Start       = 1'b0;
    frame       = 1'b0;
    input_l     = 1'b0;
    input_r     = 1'b0;
    test_reset();
    test_impulse();
    test_signed_groups();
    test_history_wrap();
    test_ready_protocol();
    $display("tests run: 5, checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0)
    begin
      $display("*** TEST PASSED ***");
    end
    else
    begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: msdap.f
source/msdap_pkg.sv
source/word_deserializer.sv
source/load_controller.sv
source/channel_store.sv
source/da_sequencer.sv
source/da_accumulator.sv
source/output_stage.sv
source/msdap.sv
bench/msdap_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing -f msdap.f --top-module msdap_tb -o msdap_sim &&
./obj_dir/msdap_sim | tee /dev/stderr | grep -F "*** TEST PASSED ***" > /dev/null &&
echo "simulation run succeeded" ||
{ echo "simulation run did not succeed"; exit 1; }

// File: source/channel_store.sv
`timescale 1ns/1ps
`default_nettype none

module channel_store
#(
  parameter int NUM_GROUPS = msdap_pkg::DEF_NUM_GROUPS,
  parameter int COEF_DEPTH = msdap_pkg::DEF_COEF_DEPTH,
  parameter int HIST_DEPTH = msdap_pkg::DEF_HIST_DEPTH
)
(
  input  logic                          Sclk,
  input  logic                          rj_we,
  input  logic                          coef_we,
  input  logic                          hist_we,
  input  logic [$clog2(COEF_DEPTH)-1:0] wr_index,
  input  msdap_pkg::word_t              wr_word,
  input  logic [$clog2(NUM_GROUPS)-1:0] rj_index,
  input  logic [$clog2(COEF_DEPTH)-1:0] coef_index,
  input  logic [$clog2(HIST_DEPTH)-1:0] hist_index,
  output msdap_pkg::word_t              rj_word,
  output msdap_pkg::word_t              coef_word,
  output msdap_pkg::word_t              hist_word
);

  import msdap_pkg::*;

  localparam int RJ_W   = $clog2(NUM_GROUPS);
  localparam int HIST_W = $clog2(HIST_DEPTH);

  word_t rj_mem   [NUM_GROUPS];
  word_t coef_mem [COEF_DEPTH];
  // ring of past samples, indexed by sample count
  word_t hist_mem [HIST_DEPTH];

  always_ff @(posedge Sclk)
  begin
    if (rj_we)
    begin
      rj_mem[wr_index[RJ_W-1:0]] <= wr_word;
    end
    if (coef_we)
    begin
      coef_mem[wr_index] <= wr_word;
    end
    if (hist_we)
    begin
      hist_mem[wr_index[HIST_W-1:0]] <= wr_word;
    end
  end

  // registered reads, data one cycle after the index
  always_ff @(posedge Sclk)
  begin
    rj_word   <= rj_mem[rj_index];
    coef_word <= coef_mem[coef_index];
    hist_word <= hist_mem[hist_index];
  end

endmodule

`default_nettype wire

// File: source/da_accumulator.sv
`timescale 1ns/1ps
`default_nettype none

module da_accumulator
(
  input  logic                        Sclk,
  input  logic                        Start,
  input  msdap_pkg::acc_op_t          acc_op,
  input  msdap_pkg::word_t            hist_word,
  output logic [msdap_pkg::ACC_W-1:0] result
);

  import msdap_pkg::*;

  localparam int EXT_W = ACC_W - WORD_W - FRAC_SHIFT;

  logic signed [ACC_W-1:0] sample_ext;
  logic signed [ACC_W-1:0] group_sum;
  logic signed [ACC_W-1:0] merged;
  logic signed [ACC_W-1:0] result_q;

  // sample scaled by 2^16 with sign extension on top
  assign sample_ext = {{EXT_W{hist_word.raw[WORD_W-1]}}, hist_word.raw, {FRAC_SHIFT{1'b0}}};
  assign merged     = result_q + group_sum;
  assign result     = result_q;

  always_ff @(posedge Sclk or negedge Start)
  begin
    if (!Start)
    begin
      group_sum <= '0;
      result_q  <= '0;
    end
    else
    begin
      case (acc_op)
        ACC_ADD:   group_sum <= group_sum + sample_ext;
        ACC_SUB:   group_sum <= group_sum - sample_ext;
        ACC_CLOSE:
        begin
          // running result halves after every group
          result_q  <= merged >>> 1;
          group_sum <= '0;
        end
        ACC_CLEAR:
        begin
          result_q  <= '0;
          group_sum <= '0;
        end
        default:   group_sum <= group_sum;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/da_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module da_sequencer
#(
  parameter int NUM_GROUPS = msdap_pkg::DEF_NUM_GROUPS,
  parameter int COEF_DEPTH = msdap_pkg::DEF_COEF_DEPTH,
  parameter int HIST_DEPTH = msdap_pkg::DEF_HIST_DEPTH
)
(
  input  logic                          Sclk,
  input  logic                          Start,
  input  logic                          start,
  input  msdap_pkg::sample_tag_t        tag,
  input  msdap_pkg::word_t              rj_word,
  input  msdap_pkg::word_t              coef_word,
  output logic [$clog2(NUM_GROUPS)-1:0] rj_index,
  output logic [$clog2(COEF_DEPTH)-1:0] coef_index,
  output logic [$clog2(HIST_DEPTH)-1:0] hist_index,
  output msdap_pkg::acc_op_t            acc_op,
  output logic                          done
);

  import msdap_pkg::*;

  localparam int RJ_W   = $clog2(NUM_GROUPS);
  localparam int COEF_W = $clog2(COEF_DEPTH);
  localparam int HIST_W = $clog2(HIST_DEPTH);
  localparam int REM_W  = COEF_W + 1;

  typedef enum logic [2:0] {
    S_IDLE,
    S_RJ_WAIT,
    S_RJ,
    S_COEF,
    S_CLOSE
  } state_t;

  state_t            state;
  sample_tag_t       tag_q;
  logic [COEF_W-1:0] coef_ptr;
  logic [REM_W-1:0]  remaining;
  acc_op_t           op_pipe;
  logic              last_pipe;
  logic              last_acc;
  logic              sample_ok;
  logic [7:0]        tap_index;

  // delayed sample exists only after enough samples came in
  assign sample_ok = tag_q.wrapped || (coef_word.coef.delay <= tag_q.index);
  assign tap_index = tag_q.index - coef_word.coef.delay;

  // read one coefficient ahead while walking a group
  assign coef_index = (state == S_COEF) ? coef_ptr + 1'b1 : coef_ptr;

  //////////////////////////////////////////////////
  // group walk
  //////////////////////////////////////////////////

  always_ff @(posedge Sclk or negedge Start)
  begin
    if (!Start)
    begin
      state     <= S_IDLE;
      rj_index  <= '0;
      coef_ptr  <= '0;
      op_pipe   <= ACC_IDLE;
      acc_op    <= ACC_IDLE;
      last_pipe <= 1'b0;
      last_acc  <= 1'b0;
      done      <= 1'b0;
    end
    else
    begin
      // two stages so each op meets its history word
      op_pipe   <= ACC_IDLE;
      last_pipe <= 1'b0;
      acc_op    <= op_pipe;
      last_acc  <= last_pipe;
      done      <= last_acc;
      case (state)
        S_IDLE:
        begin
          if (start)
          begin
            rj_index <= '0;
            coef_ptr <= '0;
            op_pipe  <= ACC_CLEAR;
            state    <= S_RJ_WAIT;
          end
        end
        S_RJ_WAIT:
        begin
          state <= S_RJ;
        end
        S_RJ:
        begin
          // an empty group still closes
          state <= (rj_word.raw == '0) ? S_CLOSE : S_COEF;
        end
        S_COEF:
        begin
          coef_ptr <= coef_ptr + 1'b1;
          if (!sample_ok)
          begin
            op_pipe <= ACC_IDLE;
          end
          else
          begin
            op_pipe <= coef_word.coef.neg ? ACC_SUB : ACC_ADD;
          end
          if (remaining == REM_W'(1))
          begin
            state <= S_CLOSE;
          end
        end
        S_CLOSE:
        begin
          op_pipe <= ACC_CLOSE;
          if (rj_index == RJ_W'(NUM_GROUPS - 1))
          begin
            last_pipe <= 1'b1;
            state     <= S_IDLE;
          end
          else
          begin
            rj_index <= rj_index + 1'b1;
            state    <= S_RJ_WAIT;
          end
        end
        default:
        begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge Sclk)
  begin
    if ((state == S_IDLE) && start)
    begin
      tag_q <= tag;
    end
    if (state == S_RJ)
    begin
      remaining <= rj_word.raw[REM_W-1:0];
    end
    else if (state == S_COEF)
    begin
      remaining <= remaining - 1'b1;
    end
    hist_index <= HIST_W'(tap_index);
  end

endmodule

`default_nettype wire

// File: source/load_controller.sv
`timescale 1ns/1ps
`default_nettype none

module load_controller
#(
  parameter int NUM_GROUPS = msdap_pkg::DEF_NUM_GROUPS,
  parameter int COEF_DEPTH = msdap_pkg::DEF_COEF_DEPTH,
  parameter int HIST_DEPTH = msdap_pkg::DEF_HIST_DEPTH
)
(
  input  logic                          Sclk,
  input  logic                          Start,
  input  logic                          word_valid,
  input  logic                          busy_done,
  output logic                          rj_we,
  output logic                          coef_we,
  output logic                          hist_we,
  output logic [$clog2(COEF_DEPTH)-1:0] wr_index,
  output logic                          start,
  output msdap_pkg::sample_tag_t        tag,
  output logic                          in_ready
);

  import msdap_pkg::*;

  localparam int COEF_W = $clog2(COEF_DEPTH);

  typedef enum logic [1:0] {
    PH_RJ,
    PH_COEF,
    PH_RUN
  } phase_t;

  phase_t            phase;
  logic [COEF_W-1:0] word_cnt;
  logic              last_word;

  assign rj_we   = word_valid && (phase == PH_RJ);
  assign coef_we = word_valid && (phase == PH_COEF);
  // samples arriving mid computation are dropped here
  assign hist_we = word_valid && (phase == PH_RUN) && in_ready;
  assign start   = hist_we;

  assign wr_index  = (phase == PH_RUN) ? COEF_W'(tag.index) : word_cnt;
  assign last_word = (phase == PH_RJ) ? (word_cnt == COEF_W'(NUM_GROUPS - 1))
                                      : (word_cnt == COEF_W'(COEF_DEPTH - 1));

  always_ff @(posedge Sclk or negedge Start)
  begin
    if (!Start)
    begin
      phase    <= PH_RJ;
      word_cnt <= '0;
      tag      <= '0;
      in_ready <= 1'b1;
    end
    else
    begin
      // load phases, rj words then coefficients
      if (rj_we || coef_we)
      begin
        if (last_word)
        begin
          word_cnt <= '0;
          phase    <= (phase == PH_RJ) ? PH_COEF : PH_RUN;
        end
        else
        begin
          word_cnt <= word_cnt + 1'b1;
        end
      end

      // run phase, one sample in flight
      if (start)
      begin
        in_ready <= 1'b0;
        if (tag.index == 8'(HIST_DEPTH - 1))
        begin
          tag.index   <= '0;
          tag.wrapped <= 1'b1;
        end
        else
        begin
          tag.index <= tag.index + 1'b1;
        end
      end
      else if (busy_done)
      begin
        in_ready <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/msdap.sv
`timescale 1ns/1ps
`default_nettype none

module msdap
#(
  parameter int NUM_GROUPS = msdap_pkg::DEF_NUM_GROUPS,
  parameter int COEF_DEPTH = msdap_pkg::DEF_COEF_DEPTH,
  parameter int HIST_DEPTH = msdap_pkg::DEF_HIST_DEPTH
)
(
  input  logic                        Sclk,
  input  logic                        Start,
  input  logic                        frame,
  input  logic                        input_l,
  input  logic                        input_r,
  output logic                        in_ready,
  output logic                        out_ready,
  output logic [msdap_pkg::ACC_W-1:0] output_l,
  output logic [msdap_pkg::ACC_W-1:0] output_r
);

  import msdap_pkg::*;

  logic                          word_valid;
  word_pair_t                    words;
  logic                          rj_we;
  logic                          coef_we;
  logic                          hist_we;
  logic [$clog2(COEF_DEPTH)-1:0] wr_index;
  logic                          start;
  sample_tag_t                   tag;
  logic                          busy_done;

  logic [$clog2(NUM_GROUPS)-1:0] rj_index_l;
  logic [$clog2(NUM_GROUPS)-1:0] rj_index_r;
  logic [$clog2(COEF_DEPTH)-1:0] coef_index_l;
  logic [$clog2(COEF_DEPTH)-1:0] coef_index_r;
  logic [$clog2(HIST_DEPTH)-1:0] hist_index_l;
  logic [$clog2(HIST_DEPTH)-1:0] hist_index_r;
  word_t                         rj_word_l;
  word_t                         rj_word_r;
  word_t                         coef_word_l;
  word_t                         coef_word_r;
  word_t                         hist_word_l;
  word_t                         hist_word_r;
  acc_op_t                       acc_op_l;
  acc_op_t                       acc_op_r;
  logic                          done_l;
  logic                          done_r;
  logic [ACC_W-1:0]              result_l;
  logic [ACC_W-1:0]              result_r;

  //////////////////////////////////////////////////
  // input capture and load control
  //////////////////////////////////////////////////

  word_deserializer word_deserializer_i (
    .Sclk(Sclk), .Start(Start), .frame(frame),
    .input_l(input_l), .input_r(input_r),
    .word_valid(word_valid), .words(words)
  );

  load_controller #(
    .NUM_GROUPS(NUM_GROUPS), .COEF_DEPTH(COEF_DEPTH), .HIST_DEPTH(HIST_DEPTH)
  ) load_controller_i (
    .Sclk(Sclk), .Start(Start), .word_valid(word_valid), .busy_done(busy_done),
    .rj_we(rj_we), .coef_we(coef_we), .hist_we(hist_we), .wr_index(wr_index),
    .start(start), .tag(tag), .in_ready(in_ready)
  );

  //////////////////////////////////////////////////
  // left channel
  //////////////////////////////////////////////////

  channel_store #(
    .NUM_GROUPS(NUM_GROUPS), .COEF_DEPTH(COEF_DEPTH), .HIST_DEPTH(HIST_DEPTH)
  ) channel_store_l (
    .Sclk(Sclk), .rj_we(rj_we), .coef_we(coef_we), .hist_we(hist_we),
    .wr_index(wr_index), .wr_word(words.left),
    .rj_index(rj_index_l), .coef_index(coef_index_l), .hist_index(hist_index_l),
    .rj_word(rj_word_l), .coef_word(coef_word_l), .hist_word(hist_word_l)
  );

  da_sequencer #(
    .NUM_GROUPS(NUM_GROUPS), .COEF_DEPTH(COEF_DEPTH), .HIST_DEPTH(HIST_DEPTH)
  ) da_sequencer_l (
    .Sclk(Sclk), .Start(Start), .start(start), .tag(tag),
    .rj_word(rj_word_l), .coef_word(coef_word_l),
    .rj_index(rj_index_l), .coef_index(coef_index_l), .hist_index(hist_index_l),
    .acc_op(acc_op_l), .done(done_l)
  );

  da_accumulator da_accumulator_l (
    .Sclk(Sclk), .Start(Start), .acc_op(acc_op_l),
    .hist_word(hist_word_l), .result(result_l)
  );

  //////////////////////////////////////////////////
  // right channel
  //////////////////////////////////////////////////

  channel_store #(
    .NUM_GROUPS(NUM_GROUPS), .COEF_DEPTH(COEF_DEPTH), .HIST_DEPTH(HIST_DEPTH)
  ) channel_store_r (
    .Sclk(Sclk), .rj_we(rj_we), .coef_we(coef_we), .hist_we(hist_we),
    .wr_index(wr_index), .wr_word(words.right),
    .rj_index(rj_index_r), .coef_index(coef_index_r), .hist_index(hist_index_r),
    .rj_word(rj_word_r), .coef_word(coef_word_r), .hist_word(hist_word_r)
  );

  da_sequencer #(
    .NUM_GROUPS(NUM_GROUPS), .COEF_DEPTH(COEF_DEPTH), .HIST_DEPTH(HIST_DEPTH)
  ) da_sequencer_r (
    .Sclk(Sclk), .Start(Start), .start(start), .tag(tag),
    .rj_word(rj_word_r), .coef_word(coef_word_r),
    .rj_index(rj_index_r), .coef_index(coef_index_r), .hist_index(hist_index_r),
    .acc_op(acc_op_r), .done(done_r)
  );

  da_accumulator da_accumulator_r (
    .Sclk(Sclk), .Start(Start), .acc_op(acc_op_r),
    .hist_word(hist_word_r), .result(result_r)
  );

  // joins both channels
  output_stage output_stage_i (
    .Sclk(Sclk), .Start(Start), .done_l(done_l), .done_r(done_r),
    .result_l(result_l), .result_r(result_r),
    .out_ready(out_ready), .output_l(output_l), .output_r(output_r),
    .busy_done(busy_done)
  );

endmodule

`default_nettype wire

// File: source/msdap_pkg.sv
`default_nettype none

package msdap_pkg;

  //////////////////////////////////////////////////
  // widths and default sizes
  //////////////////////////////////////////////////

  // serial word and datapath widths
  localparam int WORD_W     = 16;
  localparam int ACC_W      = 40;
  // sample lsb sits at this bit of the datapath
  localparam int FRAC_SHIFT = 16;

  localparam int DEF_NUM_GROUPS = 16;
  localparam int DEF_COEF_DEPTH = 512;
  // must cover the largest delay plus one
  localparam int DEF_HIST_DEPTH = 256;

  //////////////////////////////////////////////////
  // word formats
  //////////////////////////////////////////////////

  typedef struct packed {
    logic [6:0] unused;
    logic       neg;
    logic [7:0] delay;
  } coef_t;

  // same stored word, read as sample or as coefficient
  typedef union packed {
    logic signed [WORD_W-1:0] raw;
    coef_t                    coef;
  } word_t;

  typedef struct packed {
    word_t left;
    word_t right;
  } word_pair_t;

  // newest sample position in the history ring
  typedef struct packed {
    logic       wrapped;
    logic [7:0] index;
  } sample_tag_t;

  typedef enum logic [2:0] {
    ACC_IDLE,
    ACC_ADD,
    ACC_SUB,
    ACC_CLOSE,
    ACC_CLEAR
  } acc_op_t;

endpackage

`default_nettype wire

// File: source/output_stage.sv
`timescale 1ns/1ps
`default_nettype none

module output_stage
(
  input  logic                        Sclk,
  input  logic                        Start,
  input  logic                        done_l,
  input  logic                        done_r,
  input  logic [msdap_pkg::ACC_W-1:0] result_l,
  input  logic [msdap_pkg::ACC_W-1:0] result_r,
  output logic                        out_ready,
  output logic [msdap_pkg::ACC_W-1:0] output_l,
  output logic [msdap_pkg::ACC_W-1:0] output_r,
  output logic                        busy_done
);

  logic seen_l;
  logic seen_r;
  logic fin_l;
  logic fin_r;

  // channels may finish in different cycles
  assign fin_l     = seen_l | done_l;
  assign fin_r     = seen_r | done_r;
  assign busy_done = out_ready;

  always_ff @(posedge Sclk or negedge Start)
  begin
    if (!Start)
    begin
      seen_l    <= 1'b0;
      seen_r    <= 1'b0;
      out_ready <= 1'b0;
      output_l  <= '0;
      output_r  <= '0;
    end
    else
    begin
      out_ready <= 1'b0;
      if (fin_l && fin_r)
      begin
        output_l  <= result_l;
        output_r  <= result_r;
        out_ready <= 1'b1;
        seen_l    <= 1'b0;
        seen_r    <= 1'b0;
      end
      else
      begin
        seen_l <= fin_l;
        seen_r <= fin_r;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/word_deserializer.sv
`timescale 1ns/1ps
`default_nettype none

module word_deserializer
(
  input  logic                  Sclk,
  input  logic                  Start,
  input  logic                  frame,
  input  logic                  input_l,
  input  logic                  input_r,
  output logic                  word_valid,
  output msdap_pkg::word_pair_t words
);

  import msdap_pkg::*;

  localparam int CNT_W = $clog2(WORD_W);

  logic [CNT_W-1:0]  bit_cnt;
  logic [WORD_W-1:0] shift_l;
  logic [WORD_W-1:0] shift_r;

  // counter is zero while no word is in progress
  always_ff @(posedge Sclk or negedge Start)
  begin
    if (!Start)
    begin
      bit_cnt    <= '0;
      word_valid <= 1'b0;
    end
    else
    begin
      word_valid <= 1'b0;
      if (frame)
      begin
        bit_cnt <= CNT_W'(1);
      end
      else if (bit_cnt != '0)
      begin
        // last bit of the word shifts in now
        if (bit_cnt == CNT_W'(WORD_W - 1))
        begin
          bit_cnt    <= '0;
          word_valid <= 1'b1;
        end
        else
        begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
    end
  end

  // msb first
  always_ff @(posedge Sclk)
  begin
    if (frame || (bit_cnt != '0))
    begin
      shift_l <= {shift_l[WORD_W-2:0], input_l};
      shift_r <= {shift_r[WORD_W-2:0], input_r};
    end
  end

  assign words = {shift_l, shift_r};

endmodule

`default_nettype wire
